// ==== hw/i2c_consts.svh ====
// queue depth and bit timing macros, included by the i2c rtl and its testbench
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// command queue entries, any power of two from 2 up
`define I2C_QUEUE_DEPTH 4

// queue pointer width, index bits plus one wrap bit
`define I2C_PTR_W ($clog2(`I2C_QUEUE_DEPTH) + 1)

// clk cycles per quarter scl period
// one scl bit takes four quarters, 16 clk by default
`define I2C_QUARTER_CYCLES 4

`endif

// ==== hw/i2c_pkg.sv ====
// shared command, result and state types for the i2c command queue master
package i2c_pkg;

    // command opcode, value doubles as the r/w bit on the bus
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } i2c_op_e;

    // one queued command, 16 bits
    typedef struct packed {
        i2c_op_e    op;
        logic [6:0] addr;   // 7-bit target address
        logic [7:0] data;   // byte to send, unused on reads
    } i2c_cmd_t;

    // master transaction states
    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_start    = 3'd1,
        st_addr     = 3'd2,
        st_ack_addr = 3'd3,
        st_data     = 3'd4,
        st_ack_data = 3'd5,
        st_stop     = 3'd6
    } i2c_state_e;

    // per transaction result, valid with done
    typedef struct packed {
        logic [7:0] rx_data;    // received byte on reads
        logic       ack_error;  // target did not acknowledge
    } i2c_result_t;

endpackage

// ==== hw/i2c_cmd_fifo.sv ====
// circular command queue between the host and the i2c master, popped by the master
`include "i2c_consts.svh"

module i2c_cmd_fifo
    import i2c_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  i2c_cmd_t cmd,
    input  logic     push,
    input  logic     pop,
    output i2c_cmd_t head_cmd,
    output logic     full,
    output logic     empty
);
    localparam int idx_w = `I2C_PTR_W - 1;

    i2c_cmd_t             mem [`I2C_QUEUE_DEPTH];
    logic [`I2C_PTR_W-1:0] wr_ptr;
    logic [`I2C_PTR_W-1:0] rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    // pointers match except for the wrap bit when every slot is taken
    assign full  = (wr_ptr[idx_w] != rd_ptr[idx_w]) &&
                   (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign do_push = push && !full;     // dropped when full
    assign do_pop  = pop && !empty;

    assign head_cmd = mem[rd_ptr[idx_w-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[idx_w-1:0]] <= cmd;
        end
    end

    // push and pop in one cycle both move
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hw/i2c_scl_gen.sv ====
// bit timing for the i2c master fsm with four phase ticks per scl period while scl_run is high
`include "i2c_consts.svh"

module i2c_scl_gen
    import i2c_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       scl_run,
    output logic       phase_tick,
    output logic [1:0] phase
);
    localparam int cnt_w = (`I2C_QUARTER_CYCLES > 1) ? $clog2(`I2C_QUARTER_CYCLES) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(`I2C_QUARTER_CYCLES - 1);

    logic [cnt_w-1:0] cnt;

    // tick ends each quarter and phase tells which one
    assign phase_tick = scl_run && (cnt == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt   <= reload;
            phase <= 2'd0;
        end else if (!scl_run) begin
            // held so a new transaction starts on phase 0
            cnt   <= reload;
            phase <= 2'd0;
        end else if (cnt == '0) begin
            cnt   <= reload;
            phase <= phase + 2'd1;  // wraps 3 -> 0
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== hw/i2c_master_fsm.sv ====
// i2c single byte transaction engine, pops one queued command and runs start to stop
module i2c_master_fsm
    import i2c_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  i2c_cmd_t    head_cmd,
    input  logic        empty,
    output logic        pop,
    output logic        scl_run,
    input  logic        phase_tick,
    input  logic [1:0]  phase,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        scl_oe,
    output logic        sda_oe,
    output i2c_result_t result,
    output logic        done
);
    i2c_state_e state;
    i2c_op_e    op_q;
    logic [7:0] data_q;
    logic [8:0] shreg;      // bit 8 goes out first, samples enter at bit 0
    logic [2:0] bit_cnt;
    logic       ack_err;

    logic       tick_drive;
    logic       tick_rise;
    logic       tick_sample;
    logic       tick_fall;
    logic       bus_bit;

    // take the head entry straight from idle
    assign pop     = (state == st_idle) && !empty;
    assign scl_run = (state != st_idle);

    assign tick_drive  = phase_tick && (phase == 2'd0);    // set sda, scl low
    assign tick_rise   = phase_tick && (phase == 2'd1);    // release scl
    assign tick_sample = phase_tick && (phase == 2'd2);    // scl high
    assign tick_fall   = phase_tick && (phase == 2'd3);    // pull scl low

    // a sample taken with scl still low reads as 1, so a dead bus gives a nack
    assign bus_bit = sda_in | ~scl_in;

    // command and shift data
    always_ff @(posedge clk) begin
        if (pop) begin
            op_q   <= head_cmd.op;
            data_q <= head_cmd.data;
            shreg  <= {head_cmd.addr, head_cmd.op == op_read, 1'b1};
        end else if (state == st_ack_addr && tick_fall) begin
            // all ones keeps sda released while the target sends
            shreg <= (op_q == op_read) ? 9'h1ff : {data_q, 1'b1};
        end else if ((state == st_addr || state == st_data) && tick_sample) begin
            shreg <= {shreg[7:0], bus_bit};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            bit_cnt <= 3'd0;
            ack_err <= 1'b0;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (pop) begin
                        ack_err <= 1'b0;
                        state   <= st_start;
                    end
                end

                st_start: begin
                    if (tick_sample) begin
                        sda_oe <= 1'b1;     // sda falls with scl high
                    end
                    if (tick_fall) begin
                        scl_oe  <= 1'b1;
                        bit_cnt <= 3'd0;
                        state   <= st_addr;
                    end
                end

                st_addr, st_data: begin
                    if (tick_drive) begin
                        sda_oe <= ~shreg[8];
                    end
                    if (tick_rise) begin
                        scl_oe <= 1'b0;
                    end
                    if (tick_fall) begin
                        scl_oe  <= 1'b1;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= (state == st_addr) ? st_ack_addr : st_ack_data;
                        end
                    end
                end

                st_ack_addr: begin
                    if (tick_drive) begin
                        sda_oe <= 1'b0;     // target drives the ack
                    end
                    if (tick_rise) begin
                        scl_oe <= 1'b0;
                    end
                    if (tick_sample) begin
                        ack_err <= bus_bit;
                    end
                    if (tick_fall) begin
                        scl_oe <= 1'b1;
                        // no ack on the address, skip the data byte
                        state  <= ack_err ? st_stop : st_data;
                    end
                end

                st_ack_data: begin
                    // released sda is the ack slot on writes and our nack on reads
                    if (tick_drive) begin
                        sda_oe <= 1'b0;
                    end
                    if (tick_rise) begin
                        scl_oe <= 1'b0;
                    end
                    if (tick_sample && op_q == op_write) begin
                        ack_err <= bus_bit;
                    end
                    if (tick_fall) begin
                        scl_oe <= 1'b1;
                        state  <= st_stop;
                    end
                end

                st_stop: begin
                    if (tick_drive) begin
                        sda_oe <= 1'b1;     // sda low under scl low
                    end
                    if (tick_rise) begin
                        scl_oe <= 1'b0;
                    end
                    if (tick_sample) begin
                        sda_oe <= 1'b0;     // sda rises with scl high
                    end
                    if (tick_fall) begin
                        // scl stays released, bus idle
                        done             <= 1'b1;
                        result.rx_data   <= (op_q == op_read) ? shreg[7:0] : 8'h00;
                        result.ack_error <= ack_err;
                        state            <= st_idle;
                    end
                end

                default: begin
                    scl_oe <= 1'b0;
                    sda_oe <= 1'b0;
                    state  <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== hw/i2c_cmd_queue_master.sv ====
// top of the i2c command queue master, host command port in, open-drain scl/sda out
module i2c_cmd_queue_master
    import i2c_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  i2c_cmd_t    cmd,
    input  logic        cmd_push,
    output logic        queue_full,
    output logic        queue_empty,
    output i2c_result_t result,
    output logic        transfer_done,
    inout  wire         scl,
    inout  wire         sda
);
    i2c_cmd_t   head_cmd;
    logic       pop;
    logic       scl_run;
    logic       phase_tick;
    logic [1:0] phase;
    logic       scl_oe;
    logic       sda_oe;
    logic       scl_in;
    logic       sda_in;

    i2c_cmd_fifo fifo0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .cmd      (cmd),
        .push     (cmd_push),
        .pop      (pop),
        .head_cmd (head_cmd),
        .full     (queue_full),
        .empty    (queue_empty)
    );

    i2c_scl_gen scl_gen0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .scl_run    (scl_run),
        .phase_tick (phase_tick),
        .phase      (phase)
    );

    i2c_master_fsm fsm0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .head_cmd   (head_cmd),
        .empty      (queue_empty),
        .pop        (pop),
        .scl_run    (scl_run),
        .phase_tick (phase_tick),
        .phase      (phase),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe),
        .result     (result),
        .done       (transfer_done)
    );

    // open drain, low or released, pullups are off chip
    assign scl = scl_oe ? 1'b0 : 1'bz;
    assign sda = sda_oe ? 1'b0 : 1'bz;

    assign scl_in = scl;    // pin level back to the fsm
    assign sda_in = sda;

endmodule

// ==== dv/i2c_target_model.sv ====
// behavioural i2c target for the testbench, one data register behind a fixed address
module i2c_target_model #(
    parameter logic [6:0] dev_addr = 7'h50
) (
    input  wire scl,
    inout  wire sda
);
    logic       sda_low;    // pulls sda low when set
    logic       scl_prev;
    logic       sda_prev;
    logic       active;     // between start and stop
    logic       selected;   // address matched this transaction
    logic       rd;
    int         bit_no;     // scl rising edges since start
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] data_reg;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        sda_low  = 1'b0;
        scl_prev = 1'b1;
        sda_prev = 1'b1;
        active   = 1'b0;
        selected = 1'b0;
        rd       = 1'b0;
        bit_no   = 0;
        rx_shift = 8'h00;
        tx_shift = 8'h00;
        data_reg = 8'ha5;   // power up value
        forever begin
            @(scl or sda);
            if (scl_prev === 1'b1 && scl === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
                // start condition
                active   = 1'b1;
                selected = 1'b0;
                bit_no   = 0;
            end else if (scl_prev === 1'b1 && scl === 1'b1 &&
                         sda_prev === 1'b0 && sda === 1'b1) begin
                // stop condition
                active   = 1'b0;
                selected = 1'b0;
                sda_low  = 1'b0;
            end else if (active && scl_prev === 1'b0 && scl === 1'b1) begin
                bit_no = bit_no + 1;
                if (bit_no <= 8 || (bit_no >= 10 && bit_no <= 17)) begin
                    rx_shift = {rx_shift[6:0], sda === 1'b1};
                end
                if (bit_no == 8) begin
                    selected = (rx_shift[7:1] == dev_addr);
                    rd       = rx_shift[0];     // r/w bit, 1 is read
                end
                if (bit_no == 17 && selected && !rd) begin
                    data_reg = rx_shift;
                end
            end else if (active && scl_prev === 1'b1 && scl === 1'b0) begin
                sda_low = 1'b0;
                if (selected) begin
                    if (bit_no == 8) begin
                        sda_low  = 1'b1;        // address ack
                        tx_shift = data_reg;
                    end else if (rd && bit_no >= 9 && bit_no <= 16) begin
                        sda_low  = !tx_shift[7];
                        tx_shift = {tx_shift[6:0], 1'b0};
                    end else if (!rd && bit_no == 17) begin
                        sda_low = 1'b1;         // data ack
                    end
                end
            end
            scl_prev = scl;
            sda_prev = sda;
        end
    end

endmodule

// ==== dv/tb_i2c_cmd_queue_master.sv ====
// directed testbench for the i2c command queue master against a behavioural target
`include "i2c_consts.svh"

module tb_i2c_cmd_queue_master
    import i2c_pkg::*;
();
    localparam logic [6:0] target_addr    = 7'h50;
    localparam int         drive_dly      = 10;
    localparam int         cmd_cycles     = 80 * `I2C_QUARTER_CYCLES + 80;  // 400 by default
    // 5 directed commands plus the burst of depth + 1 and its read back
    localparam int         n_cmds         = `I2C_QUEUE_DEPTH + 7;
    localparam int         timeout_cycles = n_cmds * cmd_cycles + 1000;

    logic        clk;
    logic        reset_n;
    i2c_cmd_t    cmd;
    logic        cmd_push;
    logic        queue_full;
    logic        queue_empty;
    i2c_result_t result;
    logic        transfer_done;
    wire         scl;
    wire         sda;

    i2c_result_t done_q [$];
    int          done_cnt = 0;
    int          long_pulse_cnt = 0;
    logic        done_prev = 1'b0;
    int          rd_idx;
    logic [7:0]  exp_reg;   // expected target register
    int          err_cnt;
    int          check_cnt;
    int          cycle_cnt;

    pullup (scl);
    pullup (sda);

    i2c_cmd_queue_master dut0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .cmd_push      (cmd_push),
        .queue_full    (queue_full),
        .queue_empty   (queue_empty),
        .result        (result),
        .transfer_done (transfer_done),
        .scl           (scl),
        .sda           (sda)
    );

    i2c_target_model #(.dev_addr(target_addr)) target0 (.scl(scl), .sda(sda));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // results collected at negedge away from the dut edge
    always @(negedge clk) begin
        if (transfer_done === 1'b1) begin
            done_q.push_back(result);
            done_cnt = done_cnt + 1;
            if (done_prev) begin
                long_pulse_cnt = long_pulse_cnt + 1;
                $display("transfer_done stayed high for more than one cycle");
            end
        end
        done_prev = (transfer_done === 1'b1);
    end

    function automatic i2c_cmd_t make_cmd(input i2c_op_e op, input logic [6:0] addr,
                                          input logic [7:0] data);
        i2c_cmd_t c;
        c.op   = op;
        c.addr = addr;
        c.data = data;
        return c;
    endfunction

    task automatic value_error(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        err_cnt = err_cnt + 1;
        $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
    endtask

    task automatic push_cmd(input i2c_cmd_t c);
        @(posedge clk);
        #drive_dly;
        cmd      = c;
        cmd_push = 1'b1;
        @(posedge clk);
        #drive_dly;
        cmd_push = 1'b0;
    endtask

    // next result in push order against the target register rules
    task automatic check_next_result(input i2c_cmd_t c);
        i2c_result_t r;
        logic        exp_err;
        exp_err = (c.addr != target_addr);
        while (done_cnt <= rd_idx) @(posedge clk);
        r         = done_q[rd_idx];
        rd_idx    = rd_idx + 1;
        check_cnt = check_cnt + 1;
        if (r.ack_error !== exp_err) begin
            value_error("ack_error", 8'(r.ack_error), 8'(exp_err));
        end
        if (c.op == op_read && !exp_err && r.rx_data !== exp_reg) begin
            value_error("rx_data", r.rx_data, exp_reg);
        end
        if (c.op == op_write && !exp_err) begin
            exp_reg = c.data;
        end
    endtask

    task automatic check_idle_after_reset();
        check_cnt = check_cnt + 1;
        if (scl !== 1'b1) begin
            value_error("scl", 8'(scl), 8'h01);
        end
        if (sda !== 1'b1) begin
            value_error("sda", 8'(sda), 8'h01);
        end
        if (queue_empty !== 1'b1) begin
            value_error("queue_empty", 8'(queue_empty), 8'h01);
        end
        if (queue_full !== 1'b0) begin
            value_error("queue_full", 8'(queue_full), 8'h00);
        end
        repeat (20) begin
            @(negedge clk);
            if (transfer_done !== 1'b0) begin
                value_error("transfer_done", 8'(transfer_done), 8'h00);
            end
        end
    endtask

    task automatic read_power_up_value();
        push_cmd(make_cmd(op_read, target_addr, 8'h00));
        check_next_result(make_cmd(op_read, target_addr, 8'h00));
    endtask

    task automatic write_then_read_back();
        push_cmd(make_cmd(op_write, target_addr, 8'h3c));
        push_cmd(make_cmd(op_read, target_addr, 8'h00));
        check_next_result(make_cmd(op_write, target_addr, 8'h3c));
        check_next_result(make_cmd(op_read, target_addr, 8'h00));
    endtask

    task automatic write_to_absent_target();
        push_cmd(make_cmd(op_write, 7'h21, 8'h77));
        push_cmd(make_cmd(op_read, target_addr, 8'h00));
        check_next_result(make_cmd(op_write, 7'h21, 8'h77));
        check_next_result(make_cmd(op_read, target_addr, 8'h00));
    endtask

    // pushes every cycle until full, then one push that has to be dropped
    task automatic burst_until_full();
        i2c_cmd_t   sent_q [$];
        i2c_cmd_t   c;
        int         base;
        int         n;
        logic [7:0] wr_val;
        base   = done_cnt;
        n      = 0;
        wr_val = 8'h11;
        @(posedge clk);
        #drive_dly;
        while (!queue_full && n < 4 * `I2C_QUEUE_DEPTH) begin
            if (n % 2 == 0) begin
                c      = make_cmd(op_write, target_addr, wr_val);
                wr_val = wr_val + 8'h22;
            end else begin
                c = make_cmd(op_read, target_addr, 8'h00);
            end
            cmd      = c;
            cmd_push = 1'b1;
            sent_q.push_back(c);
            n = n + 1;
            @(posedge clk);
            #drive_dly;
        end
        cmd      = make_cmd(op_write, target_addr, 8'hee);
        cmd_push = 1'b1;
        @(posedge clk);
        #drive_dly;
        cmd_push  = 1'b0;
        check_cnt = check_cnt + 1;
        if (n != `I2C_QUEUE_DEPTH + 1) begin
            value_error("accepted pushes", 8'(n), 8'(`I2C_QUEUE_DEPTH + 1));
        end
        foreach (sent_q[i]) begin
            check_next_result(sent_q[i]);
        end
        repeat (cmd_cycles) @(posedge clk);     // room for a stray transaction
        check_cnt = check_cnt + 1;
        if (done_cnt != base + n) begin
            value_error("transfer_done pulses", 8'(done_cnt - base), 8'(n));
        end
        if (queue_empty !== 1'b1) begin
            value_error("queue_empty", 8'(queue_empty), 8'h01);
        end
        if (sent_q.size() > 0 && sent_q[sent_q.size() - 1].op == op_write) begin
            push_cmd(make_cmd(op_read, target_addr, 8'h00));
            check_next_result(make_cmd(op_read, target_addr, 8'h00));
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout, run did not end within %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        reset_n   = 1'b0;
        cmd       = '0;
        cmd_push  = 1'b0;
        exp_reg   = 8'ha5;
        err_cnt   = 0;
        check_cnt = 0;
        rd_idx    = 0;
        repeat (8) @(posedge clk);
        #drive_dly;
        reset_n = 1'b1;

        check_idle_after_reset();
        read_power_up_value();
        write_then_read_back();
        write_to_absent_target();
        burst_until_full();

        err_cnt = err_cnt + long_pulse_cnt;
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/i2c_pkg.sv
hw/i2c_cmd_fifo.sv
hw/i2c_scl_gen.sv
hw/i2c_master_fsm.sv
hw/i2c_cmd_queue_master.sv
dv/i2c_target_model.sv
dv/tb_i2c_cmd_queue_master.sv

// ==== Makefile ====
# Verilator lint and simulation for the i2c command queue master

VERILATOR ?= verilator
TOP       ?= tb_i2c_cmd_queue_master
RTL_TOP   ?= i2c_cmd_queue_master
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= >>> PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only if the run prints the pass line
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
